//--- bench/tcdm_tb.sv
// TCDM subsystem testbench
// LFSR-driven masters checked against a reference memory, a round-robin
// model per bank and a queue of expected responses per master
`timescale 1ns/1ps
`default_nettype none

module tcdm_tb;

  localparam int NM = tcdm_map_pkg::DEF_NB_MASTERS;
  localparam int NB = tcdm_map_pkg::DEF_NB_BANKS;
  // rows used per bank, kept small so that masters collide often
  localparam int ROWS = 64;
  localparam int DEPTH = NB * ROWS;

  logic                clk_i;
  logic                rst_n;
  logic                req     [NM];
  tcdm_bus_pkg::addr_t add     [NM];
  logic                wen     [NM];
  tcdm_bus_pkg::be_t   be      [NM];
  tcdm_bus_pkg::word_t wdata   [NM];
  logic                gnt     [NM];
  logic                r_valid [NM];
  tcdm_bus_pkg::word_t r_rdata [NM];

  // reference memory with one written flag per byte
  tcdm_bus_pkg::word_t ref_mem [DEPTH];
  logic [3:0]          ref_wr  [DEPTH];
  // round-robin pointer model, one per bank
  int                  rr_ptr  [NB];
  // expected responses per master, as due cycle, data and compare mask
  int                  due_q   [NM][$];
  tcdm_bus_pkg::word_t data_q  [NM][$];
  tcdm_bus_pkg::word_t mask_q  [NM][$];

  logic [15:0] lfsr_q;
  int cyc, checks, errors, tests, err_mark;
  // what the DUT showed in the last checked cycle
  int gnt_count, rv_count, gnt_winner;

  tcdm_subsystem UUT (
    .clk_i   (clk_i),
    .rst_n   (rst_n),
    .req     (req),
    .add     (add),
    .wen     (wen),
    .be      (be),
    .wdata   (wdata),
    .gnt     (gnt),
    .r_valid (r_valid),
    .r_rdata (r_rdata)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // one LFSR step for every bit taken
  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  // bank index sits right above the byte offset, the row above that
  function automatic int bank_of(input tcdm_bus_pkg::addr_t a);
    return int'((a >> tcdm_map_pkg::BYTE_OFFSET_BITS) % NB);
  endfunction

  function automatic int word_of(input tcdm_bus_pkg::addr_t a);
    return int'((a >> tcdm_map_pkg::BYTE_OFFSET_BITS) % DEPTH);
  endfunction

  function automatic logic [31:0] make_addr(input int bank, input int row);
    return 32'((row * NB + bank) << tcdm_map_pkg::BYTE_OFFSET_BITS);
  endfunction

  function automatic tcdm_bus_pkg::word_t byte_mask(input logic [3:0] f);
    return {{8{f[3]}}, {8{f[2]}}, {8{f[1]}}, {8{f[0]}}};
  endfunction

  function automatic logic any_req();
    logic r;
    r = 1'b0;
    for (int m = 0; m < NM; m++) r = r | req[m];
    return r;
  endfunction

  task automatic compare_value(input string name, input int idx, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("ERROR %s[%0d] got %h expected %h in cycle %0d", name, idx, got, exp, cyc);
      errors++;
    end
  endtask

  // a request is held until granted, so only idle masters take new fields
  task automatic issue(input int m, input logic [31:0] a, input logic w,
                       input tcdm_bus_pkg::be_t b, input tcdm_bus_pkg::word_t d);
    req[m]   = 1'b1;
    add[m]   = a;
    wen[m]   = w;
    be[m]    = b;
    wdata[m] = d;
  endtask

  // checks one cycle at the falling edge, advances the models and returns
  // just after the next rising edge, where new stimulus may be driven
  task automatic check_cycle();
    logic                exp_gnt [NM];
    logic                found;
    logic                due;
    int                  cand;
    int                  widx;
    tcdm_bus_pkg::word_t mask;
    tcdm_bus_pkg::word_t exp_w;
    @(negedge clk_i);
    for (int m = 0; m < NM; m++) exp_gnt[m] = 1'b0;
    // first requester at or after the pointer wins, pointer moves past it
    for (int b = 0; b < NB; b++) begin
      found = 1'b0;
      for (int k = 0; k < NM; k++) begin
        cand = (rr_ptr[b] + k) % NM;
        if (!found && req[cand] && bank_of(add[cand]) == b) begin
          found = 1'b1;
          exp_gnt[cand] = 1'b1;
          rr_ptr[b] = (cand + 1) % NM;
        end
      end
    end
    gnt_count = 0;
    rv_count = 0;
    for (int m = 0; m < NM; m++) begin
      compare_value("gnt", m, 32'(gnt[m]), 32'(exp_gnt[m]));
      if (gnt[m]) begin
        gnt_count++;
        gnt_winner = m;
      end
      if (r_valid[m]) rv_count++;
      due = (due_q[m].size() > 0) && (due_q[m][0] == cyc);
      compare_value("r_valid", m, 32'(r_valid[m]), 32'(due));
      if (due) begin
        void'(due_q[m].pop_front());
        mask = mask_q[m].pop_front();
        exp_w = data_q[m].pop_front();
        compare_value("r_rdata", m, r_rdata[m] & mask, exp_w & mask);
      end
      // the response is due one cycle after the grant
      // a read sees the word as it was before this edge
      if (exp_gnt[m]) begin
        widx = word_of(add[m]);
        due_q[m].push_back(cyc + 1);
        data_q[m].push_back(ref_mem[widx]);
        mask_q[m].push_back(wen[m] ? byte_mask(ref_wr[widx]) : '0);
        for (int by = 0; by < 4; by++) begin
          if (!wen[m] && be[m][by]) begin
            ref_mem[widx][by*8 +: 8] = wdata[m][by*8 +: 8];
            ref_wr[widx][by] = 1'b1;
          end
        end
      end
    end
    @(posedge clk_i);
    #1;
    cyc++;
    for (int m = 0; m < NM; m++) begin
      if (exp_gnt[m]) req[m] = 1'b0;
    end
  endtask

  task automatic wait_grants(input int limit);
    int n;
    n = 0;
    while (any_req() && n < limit) begin
      check_cycle();
      n++;
    end
    if (any_req()) begin
      $display("timeout: requests still waiting for a grant after %0d cycles", limit);
      errors++;
    end
  endtask

  task automatic run_idle(input int n);
    for (int i = 0; i < n; i++) check_cycle();
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %0d %s: %s, %0d errors", tests, name,
             (errors == err_mark) ? "ok" : "mismatches", errors - err_mark);
    err_mark = errors;
  endtask

  initial begin
    logic [31:0] rgo, rb, rr, rw, rbe, rd;
    int ptr0;
    int n;
    rst_n = 1'b0;
    for (int m = 0; m < NM; m++) begin
      req[m]   = 1'b0;
      add[m]   = '0;
      wen[m]   = 1'b1;
      be[m]    = '0;
      wdata[m] = '0;
    end
    for (int i = 0; i < DEPTH; i++) begin
      ref_mem[i] = '0;
      ref_wr[i]  = '0;
    end
    for (int b = 0; b < NB; b++) rr_ptr[b] = 0;
    lfsr_q = 16'd29;
    cyc = 0;
    checks = 0;
    errors = 0;
    tests = 0;
    err_mark = 0;
    repeat (16) @(posedge clk_i);
    #1;
    rst_n = 1'b1;

    // quiet bus after reset
    run_idle(8);
    end_test("idle after reset");

    // master 0 fills one word per bank, then reads them back
    for (int i = 0; i < 2 * NB; i++) begin
      issue(0, make_addr(i % NB, 3 + i % NB), (i >= NB), 4'hf, 32'hc0de_0000 + 32'(i));
      check_cycle();
      compare_value("gnt_count", i, 32'(gnt_count), 32'd1);
    end
    run_idle(1);
    end_test("write and read back");

    // byte-enable merges over a known word
    issue(1, make_addr(2, 40), 1'b0, 4'hf, 32'h1122_3344);
    wait_grants(10);
    issue(1, make_addr(2, 40), 1'b0, 4'b0101, 32'haabb_ccdd);
    wait_grants(10);
    issue(1, make_addr(2, 40), 1'b0, 4'b1000, 32'h5566_7788);
    wait_grants(10);
    issue(1, make_addr(2, 40), 1'b1, 4'h0, '0);
    wait_grants(10);
    run_idle(1);
    end_test("partial writes");

    // every master on bank 1 at once, one winner per cycle in pointer order
    ptr0 = rr_ptr[1];
    for (int m = 0; m < NM; m++) begin
      issue(m, make_addr(1, 20 + m), 1'b0, 4'hf, 32'hbeef_0000 + 32'(m));
    end
    n = 0;
    while (any_req() && n < 4 * NM) begin
      check_cycle();
      compare_value("gnt_count", n, 32'(gnt_count), 32'd1);
      compare_value("winner", n, 32'(gnt_winner), 32'((ptr0 + n) % NM));
      n++;
    end
    if (any_req()) begin
      $display("timeout: same-bank requests were not all granted in %0d cycles", 4 * NM);
      errors++;
    end
    run_idle(1);
    end_test("same bank contention");

    // every master on its own bank, writes then reads, all granted together
    for (int p = 0; p < 2; p++) begin
      for (int m = 0; m < NM; m++) begin
        issue(m, make_addr((m + 1) % NB, 50), (p == 1), 4'hf, 32'h5000_0000 + 32'(m));
      end
      check_cycle();
      compare_value("gnt_count", p, 32'(gnt_count), 32'(NM));
    end
    run_idle(1);
    compare_value("rv_count", 0, 32'(rv_count), 32'(NM));
    end_test("spread over banks");

    // random traffic from all masters
    for (int c = 0; c < 2000; c++) begin
      for (int m = 0; m < NM; m++) begin
        rand_bits(1, rgo);
        if (!req[m] && rgo[0]) begin
          rand_bits(2, rb);
          rand_bits(6, rr);
          rand_bits(1, rw);
          rand_bits(4, rbe);
          rand_bits(32, rd);
          issue(m, make_addr(int'(rb), int'(rr)), rw[0], rbe[3:0], rd);
        end
      end
      check_cycle();
    end
    wait_grants(8 * NM);
    run_idle(1);
    end_test("random traffic");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
logic/tcdm_bus_pkg.sv
logic/tcdm_map_pkg.sv
logic/tcdm_bank_sram.sv
logic/tcdm_banks_wrap.sv
logic/tcdm_bank_arbiter.sv
logic/tcdm_xbar.sv
logic/tcdm_subsystem.sv
bench/tcdm_tb.sv

//--- logic/tcdm_bank_arbiter.sv
// TCDM bank arbiter
// round-robin choice among the masters addressing one bank, with a
// zero-cycle grant and a pointer that advances past each winner
`timescale 1ns/1ps
`default_nettype none

module tcdm_bank_arbiter #(
  parameter int NB_MASTERS = 4,
  localparam int IDX_W = (NB_MASTERS > 1) ? $clog2(NB_MASTERS) : 1
) (
  input  wire                    clk_i,
  input  wire                    rst_n,
  input  wire  [NB_MASTERS-1:0]  req,
  output logic [NB_MASTERS-1:0]  gnt,
  output logic [IDX_W-1:0]       gnt_idx
);

  // master with the highest priority in the current cycle
  logic [IDX_W-1:0] ptr_q;
  // high when some master was picked this cycle
  logic             found;

  // walk the masters upward from the pointer, wrapping at the top
  // the first one with req set wins
  always_comb begin
    int cand;
    gnt     = '0;
    gnt_idx = '0;
    found   = 1'b0;
    for (int k = 0; k < NB_MASTERS; k++) begin
      cand = (int'(ptr_q) + k) % NB_MASTERS;
      if (!found && req[cand]) begin
        found        = 1'b1;
        gnt[cand]    = 1'b1;
        gnt_idx      = IDX_W'(cand);
      end
    end
  end

  // on a granted edge the winner drops to lowest priority
  // idle cycles leave the pointer alone
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      ptr_q <= '0;
    end else if (found) begin
      if (int'(gnt_idx) == NB_MASTERS - 1) begin
        ptr_q <= '0;
      end else begin
        ptr_q <= gnt_idx + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/tcdm_bank_sram.sv
// TCDM bank SRAM
// behavioral synchronous single-port memory with per-byte write enables
// and a one-cycle registered read
`timescale 1ns/1ps
`default_nettype none

module tcdm_bank_sram #(
  parameter int BANK_SIZE = 256,
  localparam int ROW_W = $clog2(BANK_SIZE),
  localparam int NB_BYTES = $bits(tcdm_bus_pkg::be_t)
) (
  input  wire                       clk_i,
  input  wire                       rst_n,
  input  wire                       csel,
  input  wire                       wr_en,
  input  wire  tcdm_bus_pkg::be_t   be,
  input  wire  [ROW_W-1:0]          addr,
  input  wire  tcdm_bus_pkg::word_t wdata,
  output tcdm_bus_pkg::word_t       rdata
);

  // storage array, one word per row
  tcdm_bus_pkg::word_t mem [BANK_SIZE];

  // write port, only the bytes flagged in be are touched
  always_ff @(posedge clk_i) begin
    if (csel && wr_en) begin
      for (int b = 0; b < NB_BYTES; b++) begin
        if (be[b]) begin
          mem[addr][b*8 +: 8] <= wdata[b*8 +: 8];
        end
      end
    end
  end

  // read register, loaded on a selected read and held otherwise
  // the word seen is the one stored before this edge
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      rdata <= '0;
    end else if (csel && !wr_en) begin
      rdata <= mem[addr];
    end
  end

endmodule

`default_nettype wire

//--- logic/tcdm_banks_wrap.sv
// TCDM bank wrapper
// one SRAM per bank, with the bus strobes turned into memory controls
`timescale 1ns/1ps
`default_nettype none

module tcdm_banks_wrap #(
  parameter int NB_BANKS = 4,
  parameter int BANK_SIZE = 256,
  localparam int ROW_W = $clog2(BANK_SIZE)
) (
  input  wire                       clk_i,
  input  wire                       rst_n,
  input  wire                       bank_req   [NB_BANKS],
  input  wire  [ROW_W-1:0]          bank_add   [NB_BANKS],
  input  wire                       bank_wen   [NB_BANKS],
  input  wire  tcdm_bus_pkg::be_t   bank_be    [NB_BANKS],
  input  wire  tcdm_bus_pkg::word_t bank_wdata [NB_BANKS],
  output tcdm_bus_pkg::word_t       bank_rdata [NB_BANKS]
);

  for (genvar i = 0; i < NB_BANKS; i++) begin : g_bank
    // the SRAM takes active-high strobes
    // the bus request selects the bank as it is, while the bus write enable
    // is low for a write and gets flipped into the write strobe
    tcdm_bank_sram #(
      .BANK_SIZE (BANK_SIZE)
    ) i_sram (
      .clk_i (clk_i),
      .rst_n (rst_n),
      .csel  (bank_req[i]),
      .wr_en (~bank_wen[i]),
      .be    (bank_be[i]),
      .addr  (bank_add[i]),
      .wdata (bank_wdata[i]),
      .rdata (bank_rdata[i])
    );
  end

endmodule

`default_nettype wire

//--- logic/tcdm_bus_pkg.sv
// TCDM bus data-path types
// word, byte-enable and address types shared by the masters, the crossbar
// and the SRAM banks
`default_nettype none

package tcdm_bus_pkg;

  // one data word as carried on every master and bank port
  typedef logic [31:0] word_t;

  // one write enable per byte of word_t
  // bit 0 covers the least significant byte
  typedef logic [3:0] be_t;

  // byte address as a master issues it
  // the crossbar looks only at the bits just above the byte offset
  typedef logic [31:0] addr_t;

endpackage

`default_nettype wire

//--- logic/tcdm_map_pkg.sv
// TCDM address map
// interleaving constants and the default sizes that the subsystem top level
// hands down to the crossbar and the banks
`default_nettype none

package tcdm_map_pkg;

  // low address bits that select a byte inside a word
  // masters always issue word-aligned requests, so these bits are ignored
  localparam int BYTE_OFFSET_BITS = 2;

  // default number of request slots on the master side
  localparam int DEF_NB_MASTERS = 4;

  // default number of word-interleaved banks
  // consecutive words land in consecutive banks, must be a power of two
  localparam int DEF_NB_BANKS = 4;

  // default depth of each bank in words, must be a power of two
  localparam int DEF_BANK_SIZE = 256;

endpackage

`default_nettype wire

//--- logic/tcdm_subsystem.sv
// TCDM subsystem top level
// word-interleaved multi-bank data memory shared by several masters
// crossbar with round-robin arbitration in front of single-port SRAM banks
`timescale 1ns/1ps
`default_nettype none

module tcdm_subsystem #(
  parameter int NB_MASTERS = tcdm_map_pkg::DEF_NB_MASTERS,
  parameter int NB_BANKS = tcdm_map_pkg::DEF_NB_BANKS,
  parameter int BANK_SIZE = tcdm_map_pkg::DEF_BANK_SIZE
) (
  input  wire                       clk_i,
  input  wire                       rst_n,
  input  wire                       req     [NB_MASTERS],
  input  wire  tcdm_bus_pkg::addr_t add     [NB_MASTERS],
  input  wire                       wen     [NB_MASTERS],
  input  wire  tcdm_bus_pkg::be_t   be      [NB_MASTERS],
  input  wire  tcdm_bus_pkg::word_t wdata   [NB_MASTERS],
  output logic                      gnt     [NB_MASTERS],
  output logic                      r_valid [NB_MASTERS],
  output tcdm_bus_pkg::word_t       r_rdata [NB_MASTERS]
);

  localparam int ROW_W = $clog2(BANK_SIZE);

  // bank-side bus between the crossbar and the memories
  logic                bank_req   [NB_BANKS];
  logic [ROW_W-1:0]    bank_add   [NB_BANKS];
  logic                bank_wen   [NB_BANKS];
  tcdm_bus_pkg::be_t   bank_be    [NB_BANKS];
  tcdm_bus_pkg::word_t bank_wdata [NB_BANKS];
  tcdm_bus_pkg::word_t bank_rdata [NB_BANKS];

  tcdm_xbar #(
    .NB_MASTERS (NB_MASTERS),
    .NB_BANKS   (NB_BANKS),
    .BANK_SIZE  (BANK_SIZE)
  ) i_xbar (
    .clk_i      (clk_i),
    .rst_n      (rst_n),
    .req        (req),
    .add        (add),
    .wen        (wen),
    .be         (be),
    .wdata      (wdata),
    .gnt        (gnt),
    .r_valid    (r_valid),
    .r_rdata    (r_rdata),
    .bank_req   (bank_req),
    .bank_add   (bank_add),
    .bank_wen   (bank_wen),
    .bank_be    (bank_be),
    .bank_wdata (bank_wdata),
    .bank_rdata (bank_rdata)
  );

  tcdm_banks_wrap #(
    .NB_BANKS  (NB_BANKS),
    .BANK_SIZE (BANK_SIZE)
  ) i_banks (
    .clk_i      (clk_i),
    .rst_n      (rst_n),
    .bank_req   (bank_req),
    .bank_add   (bank_add),
    .bank_wen   (bank_wen),
    .bank_be    (bank_be),
    .bank_wdata (bank_wdata),
    .bank_rdata (bank_rdata)
  );

endmodule

`default_nettype wire

//--- logic/tcdm_xbar.sv
// TCDM crossbar
// decodes the bank of each master request, arbitrates per bank, forwards the
// winners to the banks and routes read data back one cycle after the grant
`timescale 1ns/1ps
`default_nettype none

module tcdm_xbar #(
  parameter int NB_MASTERS = 4,
  parameter int NB_BANKS = 4,
  parameter int BANK_SIZE = 256,
  localparam int ROW_W = $clog2(BANK_SIZE),
  localparam int BANK_W = (NB_BANKS > 1) ? $clog2(NB_BANKS) : 1,
  localparam int MST_W = (NB_MASTERS > 1) ? $clog2(NB_MASTERS) : 1
) (
  input  wire                       clk_i,
  input  wire                       rst_n,
  // master side
  input  wire                       req        [NB_MASTERS],
  input  wire  tcdm_bus_pkg::addr_t add        [NB_MASTERS],
  input  wire                       wen        [NB_MASTERS],
  input  wire  tcdm_bus_pkg::be_t   be         [NB_MASTERS],
  input  wire  tcdm_bus_pkg::word_t wdata      [NB_MASTERS],
  output logic                      gnt        [NB_MASTERS],
  output logic                      r_valid    [NB_MASTERS],
  output tcdm_bus_pkg::word_t       r_rdata    [NB_MASTERS],
  // bank side
  output logic                      bank_req   [NB_BANKS],
  output logic [ROW_W-1:0]          bank_add   [NB_BANKS],
  output logic                      bank_wen   [NB_BANKS],
  output tcdm_bus_pkg::be_t         bank_be    [NB_BANKS],
  output tcdm_bus_pkg::word_t       bank_wdata [NB_BANKS],
  input  wire  tcdm_bus_pkg::word_t bank_rdata [NB_BANKS]
);

  // row bits start right above the bank index
  localparam int ROW_LSB = tcdm_map_pkg::BYTE_OFFSET_BITS + $clog2(NB_BANKS);

  // decoded target of each master
  logic [BANK_W-1:0]     bank_sel    [NB_MASTERS];
  logic [ROW_W-1:0]      row         [NB_MASTERS];
  // per bank, which masters are asking for it
  logic [NB_MASTERS-1:0] bank_mreq   [NB_BANKS];
  // per bank arbiter results
  logic [NB_MASTERS-1:0] arb_gnt     [NB_BANKS];
  logic [MST_W-1:0]      arb_idx     [NB_BANKS];
  // bank that served each master on the previous edge
  logic [BANK_W-1:0]     resp_bank_q [NB_MASTERS];

  // word-interleaved decode
  // the modulo keeps only the bits of interest, banks and rows are powers of two
  always_comb begin
    for (int m = 0; m < NB_MASTERS; m++) begin
      bank_sel[m] = BANK_W'((add[m] >> tcdm_map_pkg::BYTE_OFFSET_BITS) % NB_BANKS);
      row[m]      = ROW_W'((add[m] >> ROW_LSB) % BANK_SIZE);
    end
  end

  // spread the master requests over the banks
  always_comb begin
    for (int b = 0; b < NB_BANKS; b++) begin
      for (int m = 0; m < NB_MASTERS; m++) begin
        bank_mreq[b][m] = req[m] && (int'(bank_sel[m]) == b);
      end
    end
  end

  for (genvar b = 0; b < NB_BANKS; b++) begin : g_arb
    tcdm_bank_arbiter #(
      .NB_MASTERS (NB_MASTERS)
    ) i_arb (
      .clk_i   (clk_i),
      .rst_n   (rst_n),
      .req     (bank_mreq[b]),
      .gnt     (arb_gnt[b]),
      .gnt_idx (arb_idx[b])
    );
  end

  // each bank takes the fields of its winner
  // with no request the fields come from master 0 and are ignored
  always_comb begin
    for (int b = 0; b < NB_BANKS; b++) begin
      bank_req[b]   = |bank_mreq[b];
      bank_add[b]   = row[arb_idx[b]];
      bank_wen[b]   = wen[arb_idx[b]];
      bank_be[b]    = be[arb_idx[b]];
      bank_wdata[b] = wdata[arb_idx[b]];
    end
  end

  // a master can be granted by its own bank only, so OR over all banks
  always_comb begin
    for (int m = 0; m < NB_MASTERS; m++) begin
      gnt[m] = 1'b0;
      for (int b = 0; b < NB_BANKS; b++) begin
        gnt[m] = gnt[m] | arb_gnt[b][m];
      end
    end
  end

  // response strobe follows the grant by exactly one cycle
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      for (int m = 0; m < NB_MASTERS; m++) begin
        r_valid[m] <= 1'b0;
      end
    end else begin
      for (int m = 0; m < NB_MASTERS; m++) begin
        r_valid[m] <= gnt[m];
      end
    end
  end

  // remember which bank answers, so its read register can be steered back
  always_ff @(posedge clk_i) begin
    for (int m = 0; m < NB_MASTERS; m++) begin
      if (gnt[m]) begin
        resp_bank_q[m] <= bank_sel[m];
      end
    end
  end

  // on writes this carries whatever the bank last read, masters ignore it
  always_comb begin
    for (int m = 0; m < NB_MASTERS; m++) begin
      r_rdata[m] = bank_rdata[resp_bank_q[m]];
    end
  end

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# build the TCDM testbench with Verilator, run it and look for the pass line
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f list.f --top-module tcdm_tb -Mdir obj_dir -o tcdm_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out="$(./obj_dir/tcdm_sim)"
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TB PASSED"; then
  exit 0
fi
echo "pass line not found in simulation output"
exit 1
